/* common/image_pipe_pkg.sv */
// image pipe package: sizes, header indices, sequencer states and beat types.

package image_pipe_pkg;

  // ******************************
  // sizes
  // ******************************

  localparam int UNITS         = 4;  // output words per beat.
  localparam int WORD_WIDTH    = 8;
  localparam int KERNEL_H_MAX  = 3;  // odd.
  localparam int UNITS_EDGES   = UNITS + KERNEL_H_MAX - 1;
  localparam int BITS_KERNEL_H = 2;

  // word positions inside the header beat.
  localparam int I_IS_MAX     = 0;
  localparam int I_IS_LRELU   = 1;
  localparam int I_KERNEL_H_1 = 2;

  // ******************************
  // types
  // ******************************

  typedef enum logic [1:0] {
    SET_S  = 2'd0,  // waiting for the header.
    ONES_S = 2'd1,  // ones beats for the relu config.
    PASS_S = 2'd2   // pixel beats until last.
  } pipe_state_e;

  typedef struct packed {
    logic                     is_max;
    logic                     is_lrelu;
    logic [BITS_KERNEL_H-1:0] kernel_h_1;  // kernel height minus one.
  } image_user_t;

  typedef logic [UNITS_EDGES-1:0][WORD_WIDTH-1:0] in_word_vec_t;
  typedef logic [UNITS-1:0][WORD_WIDTH-1:0]       out_word_vec_t;

  // beat from the dma side.
  typedef struct packed {
    in_word_vec_t data;
    logic         last;
  } in_beat_t;

  // sequencer to shift buffer.
  typedef struct packed {
    in_word_vec_t data;
    image_user_t  user;
  } mid_beat_t;

  // towards the engine.
  typedef struct packed {
    out_word_vec_t data;
    image_user_t   user;
  } out_beat_t;

endpackage

/* image_pipe/config_sequencer.sv */
// config sequencer that takes the image header, sends ones beats and then passes pixels.

`timescale 1ns/1ps

module config_sequencer import image_pipe_pkg::*; (
  input  logic      aclk,
  input  logic      rst,
  input  logic      s_valid,
  input  in_beat_t  s_beat,
  output logic      s_ready,
  output logic      seq_valid,
  output mid_beat_t seq_beat,
  input  logic      seq_ready
);

  pipe_state_e              state, state_next;
  image_user_t              cfg;         // config of the current image.
  logic [BITS_KERNEL_H-1:0] ones_count;
  logic                     hdr_take;
  logic                     ones_done;

  assign hdr_take  = (state == SET_S) && s_valid && s_ready;
  assign ones_done = (ones_count == cfg.kernel_h_1) && seq_ready;

  // ******************************
  // next state and outputs
  // ******************************

  always_comb begin
    state_next    = state;
    s_ready       = 1'b0;
    seq_valid     = 1'b0;
    seq_beat.data = s_beat.data;
    seq_beat.user = cfg;
    unique case (state)
      SET_S: begin
        // header is swallowed and nothing goes downstream.
        s_ready = seq_ready;
        if (s_valid && seq_ready) begin
          state_next = ONES_S;
        end
      end
      ONES_S: begin
        seq_valid                   = 1'b1;
        seq_beat.data               = '0;
        seq_beat.data[KERNEL_H_MAX/2] = WORD_WIDTH'(1);  // centre word so no decentring.
        seq_beat.user.kernel_h_1    = '0;                // one output per ones beat.
        if (ones_done) begin
          state_next = PASS_S;
        end
      end
      PASS_S: begin
        seq_valid = s_valid;
        s_ready   = seq_ready;
        if (s_valid && seq_ready && s_beat.last) begin
          state_next = SET_S;
        end
      end
      default: begin
        state_next = SET_S;
      end
    endcase
  end

  // ******************************
  // registers
  // ******************************

  always_ff @(posedge aclk) begin
    if (rst) begin
      state      <= SET_S;
      cfg        <= '0;
      ones_count <= '0;
    end else begin
      state <= state_next;
      if (hdr_take) begin
        cfg.is_max     <= s_beat.data[I_IS_MAX][0];
        cfg.is_lrelu   <= s_beat.data[I_IS_LRELU][0];
        cfg.kernel_h_1 <= s_beat.data[I_KERNEL_H_1][BITS_KERNEL_H-1:0];
        ones_count     <= '0;
      end else if (state == ONES_S && seq_ready) begin
        // stops at kernel_h_1 and clears on the way out.
        ones_count <= ones_done ? '0 : ones_count + 1'b1;
      end
    end
  end

  // the ones counter never runs past the kernel height.
  assert property (@(posedge aclk) disable iff (rst)
    (state == ONES_S) |-> (ones_count <= cfg.kernel_h_1));

endmodule

/* shift_buffer/image_shift_buffer.sv */
// image shift buffer: decentres each beat and shifts it out once per kernel row.

`timescale 1ns/1ps

module image_shift_buffer import image_pipe_pkg::*; (
  input  logic      aclk,
  input  logic      rst,
  input  logic      seq_valid,
  input  mid_beat_t seq_beat,
  output logic      seq_ready,
  output logic      buf_valid,
  output out_beat_t buf_beat,
  input  logic      buf_ready
);

  logic [BITS_KERNEL_H-1:0] count;      // shifts still to go.
  logic [BITS_KERNEL_H-1:0] offset;
  logic                     load;
  logic                     advance;
  in_word_vec_t             dec_data;
  in_word_vec_t             shift_data;
  logic [WORD_WIDTH-1:0]    hold_top;   // top word of the held input.
  image_user_t              user_q;

  // input is blocked while shifting and while the slice is full.
  assign seq_ready = buf_ready && (count == '0);
  assign load      = seq_valid && seq_ready;
  assign advance   = buf_ready && (count != '0);

  // ******************************
  // decentring
  // ******************************

  // input is padded symmetrically but shifted one way only.
  assign offset = BITS_KERNEL_H'(KERNEL_H_MAX/2) - (seq_beat.user.kernel_h_1 >> 1);

  always_comb begin
    for (int u = 0; u < UNITS_EDGES; u++) begin
      if (u + int'(offset) < UNITS_EDGES) begin
        dec_data[u] = seq_beat.data[u + int'(offset)];
      end else begin
        dec_data[u] = '0;  // past the top edge.
      end
    end
  end

  // ******************************
  // control
  // ******************************

  always_ff @(posedge aclk) begin
    if (rst) begin
      count     <= '0;
      buf_valid <= 1'b0;
    end else if (buf_ready) begin
      if (count != '0) begin
        count     <= count - 1'b1;
        buf_valid <= 1'b1;
      end else begin
        buf_valid <= seq_valid;
        if (seq_valid) begin
          count <= seq_beat.user.kernel_h_1;
        end
      end
    end
  end

  // data path.
  always_ff @(posedge aclk) begin
    if (load) begin
      shift_data <= dec_data;
      hold_top   <= dec_data[UNITS_EDGES-1];
      user_q     <= seq_beat.user;
    end else if (advance) begin
      // down one word, top reloads.
      shift_data <= {hold_top, shift_data[UNITS_EDGES-1:1]};
    end
  end

  assign buf_beat.data = shift_data[UNITS-1:0];
  assign buf_beat.user = user_q;

  // kernel height from the header must fit the buffer edges.
  assert property (@(posedge aclk) disable iff (rst)
    load |=> (count <= BITS_KERNEL_H'(KERNEL_H_MAX - 1)));

endmodule

/* hdl/output_slice.sv */
// output slice: two-entry register slice with a registered ready.

`timescale 1ns/1ps

module output_slice import image_pipe_pkg::*; (
  input  logic      aclk,
  input  logic      rst,
  input  logic      buf_valid,
  input  out_beat_t buf_beat,
  output logic      buf_ready,
  output logic      m_valid,
  output out_beat_t m_beat,
  input  logic      m_ready
);

  logic      skid_valid;
  out_beat_t skid_beat;
  logic      main_load;   // main register free this cycle.
  logic      skid_load;

  assign buf_ready = !skid_valid;   // straight from a flop.
  assign main_load = m_ready || !m_valid;
  assign skid_load = buf_valid && buf_ready && !main_load;

  // ******************************
  // control
  // ******************************

  always_ff @(posedge aclk) begin
    if (rst) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_load) begin
      // skid drains first to keep order.
      m_valid    <= skid_valid || buf_valid;
      skid_valid <= 1'b0;
    end else if (skid_load) begin
      skid_valid <= 1'b1;
    end
  end

  // payload.
  always_ff @(posedge aclk) begin
    if (main_load) begin
      m_beat <= skid_valid ? skid_beat : buf_beat;
    end
    if (skid_load) begin
      skid_beat <= buf_beat;
    end
  end

  // a stalled beat stays put and stays valid.
  assert property (@(posedge aclk) disable iff (rst)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_beat)));

endmodule

/* hdl/image_pipe_top.sv */
// image pipe top: sequencer, shift buffer and output slice in a row.

`timescale 1ns/1ps

module image_pipe_top import image_pipe_pkg::*; (
  input  logic      aclk,
  input  logic      rst,
  input  logic      s_valid,
  input  in_beat_t  s_beat,
  output logic      s_ready,
  output logic      m_valid,
  output out_beat_t m_beat,
  input  logic      m_ready
);

  logic      seq_valid;
  logic      seq_ready;
  mid_beat_t seq_beat;
  logic      buf_valid;
  logic      buf_ready;
  out_beat_t buf_beat;

  config_sequencer config_sequencer_inst (
    .aclk      (aclk),
    .rst       (rst),
    .s_valid   (s_valid),
    .s_beat    (s_beat),
    .s_ready   (s_ready),
    .seq_valid (seq_valid),
    .seq_beat  (seq_beat),
    .seq_ready (seq_ready)
  );

  image_shift_buffer image_shift_buffer_inst (
    .aclk      (aclk),
    .rst       (rst),
    .seq_valid (seq_valid),
    .seq_beat  (seq_beat),
    .seq_ready (seq_ready),
    .buf_valid (buf_valid),
    .buf_beat  (buf_beat),
    .buf_ready (buf_ready)
  );

  output_slice output_slice_inst (
    .aclk      (aclk),
    .rst       (rst),
    .buf_valid (buf_valid),
    .buf_beat  (buf_beat),
    .buf_ready (buf_ready),
    .m_valid   (m_valid),
    .m_beat    (m_beat),
    .m_ready   (m_ready)
  );

endmodule

/* test/image_pipe_tb.sv */
// image pipe testbench that checks a table of images against a model of the output beats.

`timescale 1ns/1ps

module image_pipe_tb import image_pipe_pkg::*; ();

  localparam int          NUM_IMAGES = 6;
  localparam logic [31:0] SEED       = 32'hb521_fe85;

  typedef struct packed {
    logic                     is_max;
    logic                     is_lrelu;
    logic [BITS_KERNEL_H-1:0] kernel_h_1;
    int                       n_beats;     // pixel beats after the header.
    logic [WORD_WIDTH-1:0]    base;        // first pixel word.
  } image_case_t;

  // back to back images with alternating configs so a missed header shows up.
  image_case_t image_table [NUM_IMAGES] = '{
    '{1'b0, 1'b0, 2'd0, 3, 8'h10},
    '{1'b1, 1'b1, 2'd2, 3, 8'h40},
    '{1'b0, 1'b1, 2'd2, 2, 8'h80},
    '{1'b1, 1'b0, 2'd0, 4, 8'hc0},
    '{1'b1, 1'b1, 2'd2, 1, 8'h20},
    '{1'b0, 1'b0, 2'd0, 1, 8'h60}
  };

  logic      aclk = 1'b0;
  logic      rst;
  logic      s_valid;
  in_beat_t  s_beat;
  logic      s_ready;
  logic      m_valid;
  out_beat_t m_beat;
  logic      m_ready;

  out_beat_t expected_q [$];
  string     name_q [$];
  logic      ready_pattern [];    // m_ready per cycle drawn up front.
  int        total_beats = 0;
  int        received    = 0;
  int        cycle_count = 0;
  int        cycle_limit = 0;

  always #5 aclk = ~aclk;

  image_pipe_top image_pipe_top_inst (
    .aclk    (aclk),
    .rst     (rst),
    .s_valid (s_valid),
    .s_beat  (s_beat),
    .s_ready (s_ready),
    .m_valid (m_valid),
    .m_beat  (m_beat),
    .m_ready (m_ready)
  );

  // ******************************
  // stimulus and model
  // ******************************

  function automatic logic [WORD_WIDTH-1:0] pixel_word(input image_case_t c, input int b,
                                                       input int w);
    return WORD_WIDTH'(int'(c.base) + b * UNITS_EDGES + w);
  endfunction

  function automatic in_beat_t header_beat(input image_case_t c);
    in_beat_t beat;
    beat = '0;
    beat.data[I_IS_MAX][0]                     = c.is_max;
    beat.data[I_IS_LRELU][0]                   = c.is_lrelu;
    beat.data[I_KERNEL_H_1][BITS_KERNEL_H-1:0] = c.kernel_h_1;
    beat.data[UNITS_EDGES-1]                   = 8'h5a;  // unused word.
    return beat;
  endfunction

  function automatic in_beat_t pixel_beat(input image_case_t c, input int b);
    in_beat_t beat;
    for (int w = 0; w < UNITS_EDGES; w++) begin
      beat.data[w] = pixel_word(c, b, w);
    end
    beat.last = (b == c.n_beats - 1);
    return beat;
  endfunction

  task automatic build_expected();
    out_beat_t beat;
    int        offset;
    for (int i = 0; i < NUM_IMAGES; i++) begin
      // kernel_h ones beats with word 0 set.
      for (int k = 0; k <= int'(image_table[i].kernel_h_1); k++) begin
        beat               = '0;
        beat.data[0]       = WORD_WIDTH'(1);
        beat.user.is_max   = image_table[i].is_max;
        beat.user.is_lrelu = image_table[i].is_lrelu;
        expected_q.push_back(beat);
        name_q.push_back($sformatf("image %0d ones beat %0d", i, k));
      end
      offset = KERNEL_H_MAX / 2 - int'(image_table[i].kernel_h_1) / 2;  // de-centring.
      for (int b = 0; b < image_table[i].n_beats; b++) begin
        for (int j = 0; j <= int'(image_table[i].kernel_h_1); j++) begin
          beat.user.is_max     = image_table[i].is_max;
          beat.user.is_lrelu   = image_table[i].is_lrelu;
          beat.user.kernel_h_1 = image_table[i].kernel_h_1;
          for (int u = 0; u < UNITS; u++) begin
            beat.data[u] = pixel_word(image_table[i], b, u + offset + j);
          end
          expected_q.push_back(beat);
          name_q.push_back($sformatf("image %0d pixel beat %0d row %0d", i, b, j));
        end
      end
    end
  endtask

  // holds the beat from a falling edge until s_ready is seen high.
  task automatic send_beat(input in_beat_t beat);
    @(negedge aclk);
    s_valid = 1'b1;
    s_beat  = beat;
    #1;
    while (!s_ready) begin
      @(negedge aclk);
      #1;
    end
    @(posedge aclk);
  endtask

  // ******************************
  // checks
  // ******************************

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s expected %h actual %h", name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic take_output();
    out_beat_t exp_beat;
    string     name;
    if (expected_q.size() == 0) begin
      $display("an output beat %h came after all expected beats", m_beat);
      $display("Simulation failed");
      $fatal(1, "extra output beat");
    end else begin
      exp_beat = expected_q.pop_front();
      name     = name_q.pop_front();
      received++;
      check_value(name, 64'(exp_beat), 64'(m_beat));
    end
  endtask

  // random m_ready and beats sampled in the low clock phase.
  initial begin
    int ready_idx;
    ready_idx = 0;
    m_ready   = 1'b0;
    forever begin
      @(negedge aclk);
      if (rst) begin
        m_ready = 1'b0;
      end else begin
        m_ready = ready_pattern[ready_idx % ready_pattern.size()];
        ready_idx++;
        #1;
        if (m_valid && m_ready) begin
          take_output();
        end
      end
    end
  end

  always @(posedge aclk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("run stopped after %0d cycles with only %0d of %0d output beats received",
               cycle_count, received, total_beats);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  // ******************************
  // main sequence
  // ******************************

  initial begin
    void'($urandom(SEED));
    rst     = 1'b1;
    s_valid = 1'b0;
    s_beat  = '0;
    build_expected();
    total_beats   = expected_q.size();
    cycle_limit   = 20 * total_beats + 200;
    ready_pattern = new[cycle_limit + 1];
    foreach (ready_pattern[i]) begin
      ready_pattern[i] = ($urandom % 3) != 0;  // low about one cycle in three.
    end
    repeat (10) @(posedge aclk);
    @(negedge aclk);
    rst = 1'b0;
    for (int i = 0; i < NUM_IMAGES; i++) begin
      send_beat(header_beat(image_table[i]));
      for (int b = 0; b < image_table[i].n_beats; b++) begin
        send_beat(pixel_beat(image_table[i], b));
      end
    end
    @(negedge aclk);
    s_valid = 1'b0;
    while (expected_q.size() != 0) begin
      @(posedge aclk);
    end
    repeat (20) @(posedge aclk);  // room for a stray extra beat.
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* sim.f */
common/image_pipe_pkg.sv
image_pipe/config_sequencer.sv
shift_buffer/image_shift_buffer.sv
hdl/output_slice.sv
hdl/image_pipe_top.sv
test/image_pipe_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the image pipe testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 \
  --top-module image_pipe_tb -o image_pipe_sim -f sim.f > build.log 2>&1 \
  && ./obj_dir/image_pipe_sim > sim.log 2>&1 \
  || echo "build or simulation error, see build.log and sim.log"

grep -q "^Simulation completed successfully$" sim.log 2>/dev/null \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
